// File: snn_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// size and threshold settings for the streamed
// spiking network, included by every rtl file and
// by the testbench before any package is read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SNN_CFG_SVH
`define SNN_CFG_SVH

// number of input spike lines in a frame
`define SNN_NUM_INP 8

// number of output neurons
`define SNN_NUM_OUT 4

// a neuron fires when its summed potential reaches this level
`define SNN_THRESH 6

// membrane potential width in bits
`define SNN_POT_W 4

`endif

// File: stream_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet layout of the input and output streams
// flag positions count from the packet msb, the
// payload sits below the flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "snn_cfg.svh"

package stream_pkg;

    // flag positions, 0 is the packet msb
    localparam int SNC = 0;
    localparam int CLR = 1;
    // run flag, input packets only
    localparam int RUN = 2;

    // flag counts per direction
    localparam int NUM_IN_FLG = 3;
    localparam int NUM_OUT_FLG = 2;

    // input packet: 3 flags over the spike payload
    localparam int IN_PKT_W = NUM_IN_FLG + `SNN_NUM_INP;
    // output packet: sync and clear over the output spikes
    localparam int OUT_PKT_W = NUM_OUT_FLG + `SNN_NUM_OUT;

    // payload below the flags, meaning picked by RUN
    // RUN low  -> one spike bit per input line
    // RUN high -> number of idle steps to run with no input
    typedef union packed {
        logic [`SNN_NUM_INP-1:0] spikes;
        logic [`SNN_NUM_INP-1:0] run_len;
    } in_payload_u;

endpackage

// File: network_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// neuron types and the fixed fire rule
// input i drives neuron i mod SNN_NUM_OUT, with
// WGT_LO for the first SNN_NUM_OUT inputs and
// WGT_HI for all the others
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "snn_cfg.svh"

package network_pkg;

    // membrane potential, unsigned
    typedef logic [`SNN_POT_W-1:0] pot_t;

    // saturation level of a potential
    localparam pot_t POT_MAX = '1;

    // weight of the direct inputs and of the upper inputs
    localparam int WGT_LO = 1;
    localparam int WGT_HI = 2;

    // fire when the sum reaches this level
    localparam int FIRE_LVL = `SNN_THRESH;

endpackage

// File: stream_source.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// input stream decoder
// takes one packet at a time and turns it into
// network clear, step strobes, step inputs and a
// sync pulse
// every step waits on net_ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "snn_cfg.svh"

module stream_source (
    // global
    input  logic                           clk,
    input  logic                           arstn,
    // input stream
    input  logic [stream_pkg::IN_PKT_W-1:0] src,
    input  logic                           src_valid,
    output logic                           src_ready,
    // back-pressure from the sink
    input  logic                           net_ready,
    // network controls
    output logic                           net_arstn,
    output logic                           net_en,
    output logic [`SNN_NUM_INP-1:0]        net_inp,
    output logic                           net_sync
);

    // flag bits inside the input packet
    localparam int SNC_BIT = stream_pkg::IN_PKT_W - 1 - stream_pkg::SNC;
    localparam int CLR_BIT = stream_pkg::IN_PKT_W - 1 - stream_pkg::CLR;
    localparam int RUN_BIT = stream_pkg::IN_PKT_W - 1 - stream_pkg::RUN;

    stream_pkg::in_payload_u pay;

    logic                    accept;
    logic                    step;
    logic                    busy;
    logic                    clr_pend;
    logic                    sync_pend;
    logic [`SNN_NUM_INP-1:0] steps_left;
    logic [`SNN_NUM_INP-1:0] inp_q;

    // payload sits right under the flags
    assign pay = stream_pkg::in_payload_u'(src[`SNN_NUM_INP-1:0]);

    // a packet is pending until its clear and all its steps are out
    assign busy      = clr_pend || (steps_left != '0);
    assign src_ready = !busy;
    assign accept    = src_valid && src_ready;

    // clear cycle always comes before the first step
    assign net_arstn = !clr_pend;
    assign net_en    = (steps_left != '0) && !clr_pend;
    assign net_inp   = inp_q;
    assign step      = net_en && net_ready;

    // sync goes out in the first cycle after accept
    // which is either the clear cycle or the first step cycle
    assign net_sync = sync_pend;

    // single-cycle clear and sync requests
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            clr_pend  <= 1'b0;
            sync_pend <= 1'b0;
        end else begin
            clr_pend  <= accept && src[CLR_BIT];
            sync_pend <= accept && src[SNC_BIT];
        end
    end

    // one step for a frame and run_len steps for a run
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            steps_left <= '0;
        end else if (accept) begin
            if (src[RUN_BIT])
                steps_left <= pay.run_len;
            else
                steps_left <= `SNN_NUM_INP'(1);
        end else if (step) begin
            steps_left <= steps_left - 1'b1;
        end
    end

    // step inputs stay zero while idling through a run
    always_ff @(posedge clk) begin
        if (accept) begin
            if (src[RUN_BIT])
                inp_q <= '0;
            else
                inp_q <= pay.spikes;
        end
    end

    // the network must never step during its own clear
    a_no_step_in_clear: assert property (
        @(posedge clk) disable iff (!arstn)
        !net_arstn |-> !net_en
    ) else $error("net_en high during network clear");

endmodule

// File: spike_network.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// integrate-and-fire layer with fixed weights
// net_out is combinational in the step cycle,
// potentials move on a taken step (net_en and
// net_ready), net_arstn low zeroes every neuron
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "snn_cfg.svh"

module spike_network (
    // global
    input  logic                    clk,
    input  logic                    arstn,
    // controls from the source
    input  logic                    net_arstn,
    input  logic                    net_en,
    input  logic                    net_ready,
    input  logic [`SNN_NUM_INP-1:0] net_inp,
    // output spikes of the current step
    output logic [`SNN_NUM_OUT-1:0] net_out
);

    // widest possible sum: full potential plus every input at top weight
    localparam int SUM_MAX = int'(network_pkg::POT_MAX) + `SNN_NUM_INP * network_pkg::WGT_HI;
    localparam int SUM_W = $clog2(SUM_MAX + 1);

    network_pkg::pot_t pot [`SNN_NUM_OUT];
    logic [SUM_W-1:0]  sum [`SNN_NUM_OUT];
    logic              step;

    assign step = net_en && net_ready;

    // stored potential plus weighted inputs, per neuron
    always_comb begin
        for (int j = 0; j < `SNN_NUM_OUT; j++) begin
            sum[j] = SUM_W'(pot[j]);
            for (int i = 0; i < `SNN_NUM_INP; i++) begin
                // input i only reaches neuron i mod SNN_NUM_OUT
                if ((i % `SNN_NUM_OUT) == j && net_inp[i]) begin
                    if (i < `SNN_NUM_OUT)
                        sum[j] = sum[j] + SUM_W'(network_pkg::WGT_LO);
                    else
                        sum[j] = sum[j] + SUM_W'(network_pkg::WGT_HI);
                end
            end
            net_out[j] = (sum[j] >= SUM_W'(network_pkg::FIRE_LVL));
        end
    end

    // membrane registers
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int j = 0; j < `SNN_NUM_OUT; j++)
                pot[j] <= '0;
        end else if (!net_arstn) begin
            // clear command from the stream
            for (int j = 0; j < `SNN_NUM_OUT; j++)
                pot[j] <= '0;
        end else if (step) begin
            for (int j = 0; j < `SNN_NUM_OUT; j++) begin
                if (net_out[j])
                    // fired, start over
                    pot[j] <= '0;
                else if (sum[j] > SUM_W'(network_pkg::POT_MAX))
                    pot[j] <= network_pkg::POT_MAX;
                else
                    pot[j] <= network_pkg::pot_t'(sum[j]);
            end
        end
    end

    // a neuron at or above threshold fires, so none may rest there
    for (genvar j = 0; j < `SNN_NUM_OUT; j++) begin : g_pot_chk
        a_pot_below_thresh: assert property (
            @(posedge clk) disable iff (!arstn)
            step |=> (int'(pot[j]) <= network_pkg::FIRE_LVL - 1)
        ) else $error("neuron %0d potential at or above threshold", j);
    end

endmodule

// File: network_sink.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output packer
// every network step becomes one packet, with the
// sync and clear events seen since the last
// transfer placed above the output spikes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "snn_cfg.svh"

module network_sink (
    // global
    input  logic                             clk,
    input  logic                             arstn,
    // network handshake
    input  logic                             net_sync,
    output logic                             net_ready,
    // network results
    input  logic                             net_arstn,
    input  logic                             net_en,
    input  logic [`SNN_NUM_OUT-1:0]          net_out,
    // output stream
    input  logic                             snk_ready,
    output logic                             snk_valid,
    output logic [stream_pkg::OUT_PKT_W-1:0] snk
);

    localparam int SNC_BIT = stream_pkg::OUT_PKT_W - 1 - stream_pkg::SNC;
    localparam int CLR_BIT = stream_pkg::OUT_PKT_W - 1 - stream_pkg::CLR;
    // first spike bit right under the flags
    localparam int SPK_TOP = stream_pkg::OUT_PKT_W - 1 - stream_pkg::NUM_OUT_FLG;

    logic xfer;
    logic clr_seen;
    logic clr_rep;
    logic sync_rep;

    // a step is only taken when the packet can leave
    assign net_ready = snk_ready;
    assign snk_valid = net_en;
    assign xfer      = snk_valid && snk_ready;

    // sample the clear pulse mid-cycle, away from the edge it was launched on
    always_ff @(negedge clk or negedge arstn) begin
        if (!arstn)
            clr_seen <= 1'b0;
        else
            clr_seen <= !net_arstn;
    end

    // clear stays reported until a packet carries it out
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn)
            clr_rep <= 1'b0;
        else if (xfer)
            clr_rep <= 1'b0;
        else if (clr_seen)
            clr_rep <= 1'b1;
    end

    // same for sync, the live pulse is merged in below
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn)
            sync_rep <= 1'b0;
        else if (xfer)
            sync_rep <= 1'b0;
        else if (net_sync)
            sync_rep <= 1'b1;
    end

    // flags on top, neuron 0 right under them
    always_comb begin
        snk = '0;
        snk[SNC_BIT] = sync_rep || net_sync;
        snk[CLR_BIT] = clr_rep;
        for (int i = 0; i < `SNN_NUM_OUT; i++)
            snk[SPK_TOP - i] = net_out[i];
    end

    // stalled packet must not change, across source and network
    a_snk_stable: assert property (
        @(posedge clk) disable iff (!arstn)
        snk_valid && !snk_ready |=> $stable(snk)
    ) else $error("output packet changed while stalled");

endmodule

// File: snn_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spiking network accelerator top
// input packets -> source -> network -> sink ->
// output packets, one output packet per step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "snn_cfg.svh"

module snn_top (
    input  logic                             clk,
    input  logic                             arstn,
    // input stream
    input  logic [stream_pkg::IN_PKT_W-1:0]  src,
    input  logic                             src_valid,
    output logic                             src_ready,
    // output stream
    output logic [stream_pkg::OUT_PKT_W-1:0] snk,
    output logic                             snk_valid,
    input  logic                             snk_ready
);

    // source to network and sink
    logic                    net_arstn;
    logic                    net_en;
    logic [`SNN_NUM_INP-1:0] net_inp;
    logic                    net_sync;
    // sink back to source and network
    logic                    net_ready;
    // network to sink
    logic [`SNN_NUM_OUT-1:0] net_out;

    stream_source u_source (
        .clk, .arstn,
        .src, .src_valid, .src_ready,
        .net_ready,
        .net_arstn, .net_en, .net_inp, .net_sync
    );

    spike_network u_network (
        .clk, .arstn,
        .net_arstn, .net_en, .net_ready, .net_inp,
        .net_out
    );

    network_sink u_sink (
        .clk, .arstn,
        .net_sync, .net_ready,
        .net_arstn, .net_en, .net_out,
        .snk_ready, .snk_valid, .snk
    );

endmodule

// File: tb_snn_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the spiking network top
// reads input packets and expected output packets
// from the golden file, streams them through the
// DUT under random sink stalls and checks each
// transferred output packet in order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "snn_cfg.svh"

module tb_snn_top;

    localparam int IN_W    = stream_pkg::IN_PKT_W;
    localparam int OUT_W   = stream_pkg::OUT_PKT_W;
    localparam int RUN_BIT = IN_W - 1 - stream_pkg::RUN;
    localparam int CLK_PER = 8;

    logic             clk;
    logic             arstn;
    logic [IN_W-1:0]  src;
    logic             src_valid;
    logic             src_ready;
    logic [OUT_W-1:0] snk;
    logic             snk_valid;
    logic             snk_ready;

    // golden contents
    logic [IN_W-1:0]  in_q[$];
    logic [OUT_W-1:0] out_q[$];
    int               n_exp;
    int               n_steps;
    int               ready_pct;
    int               n_got;
    logic             loaded;
    integer           seed = 72;

    snn_top DUT (
        .clk, .arstn,
        .src, .src_valid, .src_ready,
        .snk, .snk_valid, .snk_ready
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PER / 2) clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR: %s expected %0h actual %0h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // one tag per line and # lines are skipped
    task automatic load_golden;
        int               fd;
        int               code;
        logic [63:0]      tag;
        logic [8*128-1:0] rest;
        logic [31:0]      val;
        fd = $fopen("snn_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open snn_golden.txt");
            $display("Simulation failed");
            $fatal(1, "golden file missing");
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            case (tag)
                "#": code = $fgets(rest, fd);
                "N": code = $fscanf(fd, "%d", n_exp);
                "R": code = $fscanf(fd, "%d", ready_pct);
                "I": begin
                    code = $fscanf(fd, "%h", val);
                    in_q.push_back(val[IN_W-1:0]);
                    // a run packet costs run_len steps and a frame costs one
                    if (val[RUN_BIT])
                        n_steps += int'(val[`SNN_NUM_INP-1:0]);
                    else
                        n_steps += 1;
                end
                "O": begin
                    code = $fscanf(fd, "%h", val);
                    out_q.push_back(val[OUT_W-1:0]);
                end
                default: begin
                    $display("golden file holds a line with an unknown tag");
                    $display("Simulation failed");
                    $fatal(1, "bad golden file");
                end
            endcase
        end
        $fclose(fd);
        check_val("golden packet count", n_exp, out_q.size());
    endtask

    // hold the packet until the source takes it
    task automatic send_packet(input logic [IN_W-1:0] pkt);
        src       <= pkt;
        src_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!src_ready);
    endtask

    initial begin
        src       = '0;
        src_valid = 1'b0;
        snk_ready = 1'b0;
        arstn     = 1'b0;
        n_exp     = 0;
        n_steps   = 0;
        ready_pct = 100;
        n_got     = 0;
        loaded    = 1'b0;
        load_golden();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        arstn <= 1'b1;
        @(posedge clk);
        // idle state straight after reset
        check_val("src_ready after reset", 1, src_ready);
        check_val("snk_valid after reset", 0, snk_valid);
        foreach (in_q[i])
            send_packet(in_q[i]);
        src_valid <= 1'b0;
        wait (n_got == n_exp);
        // stay a while so a stray extra packet gets caught
        repeat (10) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

    // random sink stalls
    always @(posedge clk) begin
        if (arstn)
            snk_ready <= ({$random(seed)} % 100) < ready_pct;
    end

    // compare every transferred packet with the next expected one
    always @(posedge clk) begin
        if (arstn && snk_valid && snk_ready) begin
            if (n_got >= out_q.size()) begin
                $display("DUT sent more output packets than expected");
                $display("Simulation failed");
                $fatal(1, "extra output packet");
            end else begin
                check_val($sformatf("output packet %0d", n_got), out_q[n_got], snk);
                n_got = n_got + 1;
            end
        end
    end

    // budget of 40 cycles per step plus slack for reset and drain
    initial begin
        wait (loaded);
        #((n_steps * 40 + 100) * CLK_PER);
        $display("timeout, the output stream did not finish in time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: snn_top.f
+incdir+.
stream_pkg.sv
network_pkg.sv
stream_source.sv
spike_network.sv
network_sink.sv
snn_top.sv
tb_snn_top.sv

// File: Bender.yml
package:
  name: snn_top

sources:
  - include_dirs:
      - .
    files:
      - stream_pkg.sv
      - network_pkg.sv
      - stream_source.sv
      - spike_network.sv
      - network_sink.sv
      - snn_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_snn_top.sv

// File: snn_golden.txt
# N <dec>: expected output packets, R <dec>: sink ready chance in percent
# I <hex>: input packet, snc clr run flags over 8 payload bits
# O <hex>: expected output packet, snc clr flags over neuron 0..3 spikes
N 28
R 60
I 0ff
I 0ff
I 021
I 021
I 021
I 021
I 103
I 021
I 021
I 088
I 044
I 2cc
I 0cc
I 4f0
I 0f0
I 0f0
I 702
I 00f
I 301
I 0ff
I 4ff
I 011
I 011
I 011
I 011
O 00
O 0f
O 00
O 00
O 04
O 00
O 00
O 00
O 00
O 00
O 0c
O 00
O 00
O 10
O 03
O 20
O 00
O 0f
O 30
O 00
O 00
O 10
O 00
O 2f
O 00
O 08
O 00
O 08
